// File: hw/sw_params.svh
// score width, element count and biased zero, included by the package, RTL and testbench
`ifndef SW_PARAMS_SVH
`define SW_PARAMS_SVH

// ============================================================================
// array geometry
// ============================================================================

// bits per score word
`define SW_SCORE_WIDTH 12

// one element per query base
`define SW_PE_COUNT 4

// ============================================================================
// score encoding
// ============================================================================

// scores are biased by half the range, so this is the local-alignment floor
`define SW_ZERO (1 << (`SW_SCORE_WIDTH - 1))

`endif

// File: hw/sw_pkg.sv
// shared score, base, penalty and column types, imported by every array module
`include "sw_params.svh"

package sw_pkg;

	typedef logic [`SW_SCORE_WIDTH-1:0] score_t;	// biased score or 2's-compl penalty
	typedef logic [1:0] base_t;			// nucleotide code

	typedef struct packed {
		score_t match;			// added on equal bases
		score_t mismatch;		// added on differing bases
		score_t gap_open;		// added when a gap starts
		score_t gap_extend;		// added for every gap base
	} sw_penalty_t;

	// one element's hand-off to its right neighbour
	typedef struct packed {
		logic en;			// item valid
		base_t base;			// target base travelling right
		score_t m;			// match matrix score
		score_t i;			// indel matrix score
	} sw_col_t;

	// gap stage to cell stage
	typedef struct packed {
		logic en;
		base_t base;
		score_t lut;			// match or mismatch for this item
		score_t diag_max;		// larger diagonal score
		score_t m_open;			// gap-open candidate
		score_t i_extend;		// gap-extend candidate
	} sw_gap_t;

	typedef enum logic {IDLE, CALC} sw_state_t;	// burst state per stage

	// unsigned compare is valid on biased scores
	function automatic score_t max_score(input score_t a, input score_t b);
		return (a > b) ? a : b;
	endfunction

endpackage

// File: hw/sw_gap_stage.sv
// element stage 1, latches the left column and forms the diagonal max and gap candidates
`timescale 1ns/100ps
`include "sw_params.svh"

module sw_gap_stage
	import sw_pkg::*;
(
	input logic clk,
	input logic rst,
	input sw_col_t col_left,		// column from left neighbour
	input base_t query_base,		// base held by this element
	input sw_penalty_t penalty,
	input score_t m_up,			// own m of the previous item
	input score_t i_up,			// own i of the previous item
	output sw_gap_t stage_out
);

	localparam score_t ZERO = score_t'(`SW_ZERO);

	sw_state_t state;			// CALC while a burst is in flight
	logic first_q;				// registered item opens the burst
	base_t base_q;
	score_t lut_q;
	score_t diag_max_q;
	score_t m_left_q;			// left m, also next item's diagonal
	score_t i_left_q;			// left i, also next item's diagonal

	score_t lut;
	score_t diag_max;
	score_t m_up_sel;
	score_t i_up_sel;

	// ========================================================================
	// input side, one cycle ahead of the register
	// ========================================================================

	always_comb
	begin
		lut = (col_left.base == query_base) ? penalty.match : penalty.mismatch;
		// first item has no diagonal inside the matrix
		diag_max = (state == CALC) ? max_score(m_left_q, i_left_q) : ZERO;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= IDLE;
			first_q <= 1'b0;
			base_q <= '0;
			lut_q <= ZERO;
			diag_max_q <= ZERO;
			m_left_q <= ZERO;
			i_left_q <= ZERO;
		end
		else
		begin
			if (col_left.en)
			begin
				first_q <= (state == IDLE);	// IDLE means burst start
				base_q <= col_left.base;
				lut_q <= lut;
				diag_max_q <= diag_max;
				m_left_q <= col_left.m;
				i_left_q <= col_left.i;
			end
			else if (state == IDLE)
			begin
				first_q <= 1'b0;		// park at biased zero
				base_q <= '0;
				lut_q <= ZERO;
				diag_max_q <= ZERO;
				m_left_q <= ZERO;
				i_left_q <= ZERO;
			end
			case (state)
				IDLE: if (col_left.en) state <= CALC;
				CALC: if (!col_left.en) state <= IDLE;
			endcase
		end
	end

	// ========================================================================
	// output side, gap candidates after the register
	// ========================================================================

	// up comes from the cell register, which holds the previous item here
	always_comb
	begin
		m_up_sel = first_q ? ZERO : m_up;	// no up neighbour on first row
		i_up_sel = first_q ? ZERO : i_up;
		stage_out.en = (state == CALC);
		stage_out.base = base_q;
		stage_out.lut = lut_q;
		stage_out.diag_max = diag_max_q;
		stage_out.m_open = max_score(m_left_q, m_up_sel) + penalty.gap_open
			+ penalty.gap_extend;		// open pays both penalties
		stage_out.i_extend = max_score(i_left_q, i_up_sel) + penalty.gap_extend;
	end

endmodule

// File: hw/sw_cell_stage.sv
// element stage 2, forms the clamped m and the gap i and registers the column to the right
`timescale 1ns/100ps
`include "sw_params.svh"

module sw_cell_stage
	import sw_pkg::*;
(
	input logic clk,
	input logic rst,
	input sw_gap_t stage_in,		// from gap stage
	output sw_col_t col_right		// to right neighbour and own gap stage
);

	localparam score_t ZERO = score_t'(`SW_ZERO);

	sw_state_t state;
	base_t base_q;
	score_t m_q;
	score_t i_q;

	score_t m_sum;
	score_t m_bus;
	score_t i_bus;

	// ========================================================================
	// score forming
	// ========================================================================

	always_comb
	begin
		m_sum = stage_in.lut + stage_in.diag_max;	// wraps, lut may be negative
		m_bus = (m_sum >= ZERO) ? m_sum : ZERO;		// local floor
		i_bus = max_score(stage_in.m_open, stage_in.i_extend);
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= IDLE;
			base_q <= '0;
			m_q <= ZERO;
			i_q <= ZERO;
		end
		else
		begin
			if (stage_in.en)
			begin
				base_q <= stage_in.base;	// base moves on with its scores
				m_q <= m_bus;
				i_q <= i_bus;
			end
			else if (state == IDLE)
			begin
				base_q <= '0;			// one cycle after burst end
				m_q <= ZERO;
				i_q <= ZERO;
			end
			case (state)
				IDLE: if (stage_in.en) state <= CALC;
				CALC: if (!stage_in.en) state <= IDLE;
			endcase
		end
	end

	// column word to the right
	always_comb
	begin
		col_right.en = (state == CALC);
		col_right.base = base_q;
		col_right.m = m_q;
		col_right.i = i_q;
	end

endmodule

// File: hw/sw_high_stage.sv
// element stage 3, keeps the running best score and pulses valid at the end of a burst
`timescale 1ns/100ps
`include "sw_params.svh"

module sw_high_stage
	import sw_pkg::*;
(
	input logic clk,
	input logic rst,
	input sw_col_t col_right,		// this element's column
	input score_t high_left,		// best so far from the left
	output score_t high_right,		// best so far to the right
	output logic vld			// one-cycle result strobe
);

	localparam score_t ZERO = score_t'(`SW_ZERO);

	sw_state_t state;

	score_t mi_max;
	score_t high_prev;
	score_t high_bus;

	// ========================================================================
	// high score reduction
	// ========================================================================

	always_comb
	begin
		mi_max = max_score(col_right.m, col_right.i);
		// own history only counts once the burst has started
		high_prev = (state == CALC) ? max_score(high_left, high_right) : high_left;
		high_bus = max_score(high_prev, mi_max);
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= IDLE;
			vld <= 1'b0;
			high_right <= ZERO;
		end
		else
		begin
			vld <= 1'b0;				// pulse lasts one cycle
			case (state)
				IDLE:
				begin
					if (col_right.en)
					begin
						high_right <= high_bus;
						state <= CALC;
					end
					else
						high_right <= ZERO;	// clear after result shown
				end
				CALC:
				begin
					if (col_right.en)
						high_right <= high_bus;
					else
					begin
						vld <= 1'b1;		// burst done, hold result
						state <= IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/sw_array.sv
// top level, a linear systolic Smith-Waterman array, one element per query base
`timescale 1ns/100ps
`include "sw_params.svh"

module sw_array
	import sw_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic target_en,			// high for each burst cycle
	input base_t target_base,
	input base_t [`SW_PE_COUNT-1:0] query,	// element k holds query[k]
	input sw_penalty_t penalty,		// steady during a burst
	output score_t best_score,
	output logic best_vld
);

	localparam int PE_COUNT = `SW_PE_COUNT;
	localparam score_t ZERO = score_t'(`SW_ZERO);

	// ========================================================================
	// inter-element wiring
	// ========================================================================

	sw_col_t col [0:PE_COUNT];		// col[k] enters element k
	score_t high [0:PE_COUNT];		// high[k] enters element k
	logic [PE_COUNT-1:0] vld_pe;		// per-element result strobe

	// left boundary of the matrix is biased zero
	always_comb
	begin
		col[0].en = target_en;
		col[0].base = target_base;
		col[0].m = ZERO;
		col[0].i = ZERO;
		high[0] = ZERO;
	end

	// ========================================================================
	// element chain
	// ========================================================================

	for (genvar k = 0; k < PE_COUNT; k++)
	begin : g_pe
		sw_gap_t gap;				// stage 1 to stage 2

		sw_gap_stage u_gap (
			.clk(clk),
			.rst(rst),
			.col_left(col[k]),
			.query_base(query[k]),
			.penalty(penalty),
			.m_up(col[k+1].m),		// own output fed back
			.i_up(col[k+1].i),
			.stage_out(gap)
		);

		sw_cell_stage u_cell (
			.clk(clk),
			.rst(rst),
			.stage_in(gap),
			.col_right(col[k+1])
		);

		sw_high_stage u_high (
			.clk(clk),
			.rst(rst),
			.col_right(col[k+1]),
			.high_left(high[k]),
			.high_right(high[k+1]),
			.vld(vld_pe[k])
		);
	end

	// last element carries the alignment result
	assign best_score = high[PE_COUNT];
	assign best_vld = vld_pe[PE_COUNT-1];

endmodule

// File: test/sw_ref_model.svh
// reference alignment score and LFSR step, included inside the sw_array testbench module
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

// ============================================================================
// random source
// ============================================================================

// x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the lsb
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

function automatic int int_max(input int a, input int b);
	return (a > b) ? a : b;
endfunction

// ============================================================================
// alignment score
// ============================================================================

// matrix filled row by row, one row per target base, scores unbiased
function automatic int ref_score(input query_t q, input int len, input target_t t,
	input int match, input int mismatch, input int gap_open, input int gap_extend);
	int m_up [0:`SW_PE_COUNT];		// previous row, index 0 lies outside
	int i_up [0:`SW_PE_COUNT];
	int m_cur [0:`SW_PE_COUNT];		// row being filled
	int i_cur [0:`SW_PE_COUNT];
	int best;
	int s;
	int r;
	int j;
	best = 0;				// local alignment never below zero
	for (j = 0; j <= `SW_PE_COUNT; j++)
	begin
		m_up[j] = 0;			// row above the matrix
		i_up[j] = 0;
	end
	for (r = 0; r < len; r++)
	begin
		m_cur[0] = 0;			// column left of the matrix
		i_cur[0] = 0;
		for (j = 1; j <= `SW_PE_COUNT; j++)
		begin
			s = (t[r] == q[j-1]) ? match : mismatch;
			m_cur[j] = int_max(0, s + int_max(m_up[j-1], i_up[j-1]));
			// gap open pays open and extend, extension pays extend
			i_cur[j] = int_max(int_max(m_cur[j-1], m_up[j]) + gap_open + gap_extend,
				int_max(i_cur[j-1], i_up[j]) + gap_extend);
			best = int_max(best, int_max(m_cur[j], i_cur[j]));
		end
		m_up = m_cur;
		i_up = i_cur;
	end
	return best;
endfunction

`endif

// File: test/sw_array_tb.sv
// testbench for sw_array, applies a table of fixed and LFSR cases and checks score and strobe
`timescale 1ns/100ps
`include "sw_params.svh"

module sw_array_tb
	import sw_pkg::*;
();

	localparam int PE_COUNT = `SW_PE_COUNT;
	localparam int MAX_LEN = 8;			// longest target burst
	localparam int NUM_FIXED = 3;
	localparam int NUM_RANDOM = 8;
	localparam int NUM_CASES = NUM_FIXED + NUM_RANDOM;

	typedef base_t [PE_COUNT-1:0] query_t;
	typedef base_t [MAX_LEN-1:0] target_t;		// index 0 is sent first

	typedef struct packed {
		query_t query;
		int len;				// bases in the burst
		target_t target;
		sw_penalty_t pen;
		int score_exp;				// expected score above biased zero
	} case_t;

	`include "sw_ref_model.svh"

	logic clk;
	logic rst;
	logic target_en;
	base_t target_base;
	query_t query;
	sw_penalty_t penalty;
	score_t best_score;
	logic best_vld;

	case_t cases [NUM_CASES];
	string case_name [NUM_CASES];
	int case_count = 0;
	logic [15:0] lfsr_state;
	int cycle_count = 0;
	int cycle_limit;
	int vld_total = 0;				// strobes seen over the whole run

	sw_array DUT (
		.clk(clk),
		.rst(rst),
		.target_en(target_en),
		.target_base(target_base),
		.query(query),
		.penalty(penalty),
		.best_score(best_score),
		.best_vld(best_vld)
	);

	// ========================================================================
	// clock, run limit, strobe monitor
	// ========================================================================

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;			// 8 ns period
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout, no result after %0d cycles", cycle_count);
			$display("CHECKS FAILED");
			$fatal(1, "run limit reached");
		end
	end

	always @(negedge clk)
	begin
		if (best_vld === 1'b1)
		begin
			if (!rst)
			begin
				$display("best_vld was raised while reset was held");
				$display("CHECKS FAILED");
				$fatal(1, "strobe during reset");
			end
			else
				vld_total++;
		end
	end

	// ========================================================================
	// case table
	// ========================================================================

	// A=0 G=1 T=2 C=3
	function automatic target_t seq_to_bases(input string seq);
		target_t bases;
		int idx;
		bases = '0;
		for (idx = 0; idx < seq.len(); idx++)
		begin
			case (seq[idx])
				"A": bases[idx] = 2'd0;
				"G": bases[idx] = 2'd1;
				"T": bases[idx] = 2'd2;
				default: bases[idx] = 2'd3;	// C
			endcase
		end
		return bases;
	endfunction

	function automatic int take_bits(input int count);
		int value;
		int b;
		value = 0;
		for (b = 0; b < count; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			value = value * 2 + int'(lfsr_state[0]);
		end
		return value;
	endfunction

	function automatic string random_seq(input int len);
		string letters;
		string seq;
		int idx;
		int pick;
		letters = "AGTC";
		seq = "";
		for (idx = 0; idx < len; idx++)
		begin
			pick = take_bits(2);
			seq = {seq, letters.substr(pick, pick)};
		end
		return seq;
	endfunction

	function automatic void add_case(input string name, input string query_seq,
		input string target_seq, input int match, input int mismatch,
		input int gap_open, input int gap_extend, input int score_exp);
		target_t query_bases;
		query_bases = seq_to_bases(query_seq);
		case_name[case_count] = name;
		cases[case_count].query = query_bases[PE_COUNT-1:0];
		cases[case_count].len = target_seq.len();
		cases[case_count].target = seq_to_bases(target_seq);
		cases[case_count].pen.match = score_t'(match);		// 2's complement
		cases[case_count].pen.mismatch = score_t'(mismatch);
		cases[case_count].pen.gap_open = score_t'(gap_open);
		cases[case_count].pen.gap_extend = score_t'(gap_extend);
		cases[case_count].score_exp = score_exp;
		case_count++;
	endfunction

	task automatic build_table();
		string q_seq;
		string t_seq;
		int n;
		int len;
		int idx;
		add_case("identical", "AGTC", "AGTC", 2, -1, -2, -1, 8);	// 4 matches
		add_case("all_mismatch", "AAGG", "TCTC", 2, -1, -2, -1, 0);	// clamped
		add_case("one_insert", "AGTC", "AGATC", 3, -3, -2, -1, 9);	// AG, gap, TC
		for (n = 0; n < NUM_RANDOM; n++)
		begin
			len = 3 + take_bits(3) % 6;		// 3 to 8 bases
			q_seq = random_seq(PE_COUNT);
			t_seq = random_seq(len);
			idx = case_count;
			add_case($sformatf("random_%0d", n), q_seq, t_seq, 2, -1, -3, -1, 0);
			cases[idx].score_exp = ref_score(cases[idx].query, cases[idx].len,
				cases[idx].target, 2, -1, -3, -1);
		end
	endtask

	// ========================================================================
	// drive and compare
	// ========================================================================

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic run_case(input int idx);
		case_t tc;
		int r;
		int cyc;
		int n;
		tc = cases[idx];
		for (r = 0; r < tc.len; r++)
		begin
			@(posedge clk);
			query <= tc.query;			// held through the burst
			penalty <= tc.pen;
			target_en <= 1'b1;
			target_base <= tc.target[r];
		end
		@(posedge clk);
		target_en <= 1'b0;				// cycle n, burst over
		target_base <= '0;
		cyc = tc.len;
		@(negedge clk);
		while (!best_vld)
		begin
			@(negedge clk);
			cyc++;
		end
		check_value({case_name[idx], " vld cycle"}, tc.len + 2 * PE_COUNT + 1, cyc);
		check_value(case_name[idx], tc.score_exp, int'(best_score) - `SW_ZERO);
		for (n = 0; n < 3; n++)
		begin
			@(negedge clk);			// strobe must not repeat
			check_value({case_name[idx], " single vld"}, 0, int'(best_vld));
		end
	endtask

	initial
	begin
		int total_len;
		int idx;
		rst <= 1'b0;
		target_en <= 1'b0;
		target_base <= '0;
		query <= '0;
		penalty <= '0;
		lfsr_state = 16'd17;				// seed
		build_table();
		total_len = 0;
		for (idx = 0; idx < NUM_CASES; idx++)
			total_len += cases[idx].len;
		cycle_limit = total_len + NUM_CASES * (2 * PE_COUNT + 8) + 10;	// + reset
		repeat (5) @(posedge clk);
		rst <= 1'b1;
		for (idx = 0; idx < NUM_CASES; idx++)
			run_case(idx);
		@(posedge clk);
		if (vld_total != NUM_CASES)
		begin
			$display("best_vld pulsed %0d times for %0d bursts", vld_total, NUM_CASES);
			$display("CHECKS FAILED");
			$fatal(1, "wrong strobe count");
		end
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// File: sw_array.f
+incdir+hw
+incdir+test
hw/sw_pkg.sv
hw/sw_gap_stage.sv
hw/sw_cell_stage.sv
hw/sw_high_stage.sv
hw/sw_array.sv
test/sw_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the sw_array testbench with Verilator and runs it
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sw_array_tb -f sw_array.f -o sw_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sw_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
